// ==== common/cache_macros.svh ====
// cache geometry and memory timing shared by RTL and testbench
// include wherever the constants are needed
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// sets per way, tied to the 3-bit index field
`define CACHE_NUM_LINES 8

// default number of ways
`define CACHE_WAYS 2

// cycles from first stb sample to ack
`define MEM_ACK_LATENCY 2

`endif

// ==== common/cache_pkg.sv ====
// types shared by the cache, arbiter and memory
// import where a module uses the line, address or bus types
package cache_pkg;

    // ----------------------------------------
    // vectors
    // ----------------------------------------
    typedef logic [127:0] line_t;   // one cache line
    typedef logic [15:0]  sel_t;    // one bit per byte of a line
    typedef logic [11:0]  adr_t;    // line address
    typedef logic [8:0]   tag_t;    // adr[11:3]
    typedef logic [2:0]   index_t;  // adr[2:0]

    // ----------------------------------------
    // wishbone-style bus, line wide
    // ----------------------------------------
    typedef struct packed {
        logic  stb;
        logic  we;
        adr_t  adr;
        sel_t  sel;
        line_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;   // one-cycle pulse
        line_t dat;
    } wb_rsp_t;

    // cache controller
    typedef enum logic [1:0] {
        idle,
        compare,
        writeback,
        refill
    } ctrl_state_t;

endpackage

// ==== cache/cache_way.sv ====
// one way of the set-associative cache: valid, dirty, tag and data per set
// arrays read asynchronously at index_in, written on load
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_way
    import cache_pkg::*;
#(
    parameter int NUM_LINES = `CACHE_NUM_LINES
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   load,
    input  logic   load_type,   // 0 cpu write, 1 refill
    input  sel_t   byte_sel,
    input  tag_t   tag_in,
    input  index_t index_in,
    input  line_t  data_in,
    output line_t  data_out,
    output tag_t   tag_out,
    output logic   dirty_out,
    output logic   hit_out
);

    logic [NUM_LINES-1:0] valid;
    logic [NUM_LINES-1:0] dirty;
    tag_t                 tags [NUM_LINES];
    line_t                data [NUM_LINES];

    // status bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (load) begin
            if (load_type) valid[index_in] <= 1'b1;
            dirty[index_in] <= ~load_type;  // refill clean, cpu write dirty
        end
    end

    // tag and data, bytes merged under byte_sel
    always_ff @(posedge clk) begin
        if (load) begin
            if (load_type) tags[index_in] <= tag_in;
            for (int b = 0; b < $bits(sel_t); b++) begin
                if (byte_sel[b]) data[index_in][8*b +: 8] <= data_in[8*b +: 8];
            end
        end
    end

    assign data_out  = data[index_in];
    assign tag_out   = tags[index_in];
    assign dirty_out = dirty[index_in];
    assign hit_out   = valid[index_in] && (tags[index_in] == tag_in);

endmodule

// ==== cache/cache_lru.sv ====
// replacement record per set, a pseudo-LRU tree of ASSOCIATIVITY-1 bits
// with 2 ways the single node is just the complement of the last used way
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_lru
    import cache_pkg::*;
#(
    parameter int ASSOCIATIVITY = `CACHE_WAYS
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] mru_in,
    input  index_t                           index_in,
    input  logic                             load_in,
    output logic [$clog2(ASSOCIATIVITY)-1:0] lru_out
);

    localparam int LEVELS = $clog2(ASSOCIATIVITY);

    // heap order, node 1 is the root
    logic [ASSOCIATIVITY-1:1] tree [`CACHE_NUM_LINES];
    logic [ASSOCIATIVITY-1:1] tree_cur;
    logic [ASSOCIATIVITY-1:1] tree_next;
    int unsigned              upd_node;
    int unsigned              rd_node;

    assign tree_cur = tree[index_in];

    // every node on the path points away from the used way
    always_comb begin
        tree_next = tree_cur;
        upd_node  = 1;
        for (int lvl = LEVELS - 1; lvl >= 0; lvl--) begin
            tree_next[upd_node] = ~mru_in[lvl];
            upd_node = 2 * upd_node + mru_in[lvl];
        end
    end

    // follow the pointers down to the victim
    always_comb begin
        lru_out = '0;
        rd_node = 1;
        for (int lvl = LEVELS - 1; lvl >= 0; lvl--) begin
            lru_out[lvl] = tree_cur[rd_node];
            rd_node = 2 * rd_node + tree_cur[rd_node];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_NUM_LINES; s++) tree[s] <= '0;
        end else if (load_in) begin
            tree[index_in] <= tree_next;
        end
    end

endmodule

// ==== cache/cache_datapath.sv ====
// cache datapath: steers data, selects, tag and load between the cpu bus,
// the ways and the memory bus under the controller's selects
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_datapath
    import cache_pkg::*;
#(
    parameter int ASSOCIATIVITY = `CACHE_WAYS
) (
    input  logic                             clk,
    input  logic                             reset,

    // from controller
    input  logic [$clog2(ASSOCIATIVITY)-1:0] cache_way_sel,
    input  logic                             input_data_source_sel,  // 1 on refill
    input  logic                             tag_bypass_sel,         // 1 on refill
    input  logic                             load,
    input  logic                             load_lru,

    // cpu and memory side
    input  wb_req_t                          cpu_req,
    input  line_t                            mem_rdata,

    // to controller
    output logic [ASSOCIATIVITY-1:0]         hit,
    output logic                             dirty,
    output logic [$clog2(ASSOCIATIVITY)-1:0] lru,

    output line_t                            cpu_rdata,
    output adr_t                             mem_adr,
    output sel_t                             mem_sel,
    output line_t                            mem_wdata
);

    tag_t                     req_tag;
    index_t                   index;
    line_t                    data_in;
    sel_t                     byte_sel;
    logic [ASSOCIATIVITY-1:0] load_vec;
    line_t [ASSOCIATIVITY-1:0] way_data;
    tag_t  [ASSOCIATIVITY-1:0] way_tag;
    logic [ASSOCIATIVITY-1:0] way_dirty;
    line_t                    data_sel;
    tag_t                     tag_sel;

    assign req_tag = cpu_req.adr[11:3];
    assign index   = cpu_req.adr[2:0];

    // ----------------------------------------
    // into the ways
    // ----------------------------------------
    assign mem_sel  = '1;  // memory always moves whole lines
    assign data_in  = input_data_source_sel ? mem_rdata : cpu_req.dat;
    assign byte_sel = input_data_source_sel ? mem_sel : cpu_req.sel;

    // load goes to the selected way only
    always_comb begin
        load_vec = '0;
        load_vec[cache_way_sel] = load;
    end

    // ----------------------------------------
    // out of the ways
    // ----------------------------------------
    assign data_sel  = way_data[cache_way_sel];
    assign tag_sel   = way_tag[cache_way_sel];
    assign cpu_rdata = data_sel;
    assign mem_wdata = data_sel;

    // victim tag for writeback, request tag for refill
    assign mem_adr = {tag_bypass_sel ? req_tag : tag_sel, index};

    assign dirty = way_dirty[lru];  // decides writeback on a miss

    // ----------------------------------------
    // ways and replacement
    // ----------------------------------------
    cache_way #(
        .NUM_LINES(`CACHE_NUM_LINES)
    ) way_inst [ASSOCIATIVITY-1:0] (
        .clk       (clk),
        .reset     (reset),
        .load      (load_vec),
        .load_type (input_data_source_sel),
        .byte_sel  (byte_sel),
        .tag_in    (req_tag),
        .index_in  (index),
        .data_in   (data_in),
        .data_out  (way_data),
        .tag_out   (way_tag),
        .dirty_out (way_dirty),
        .hit_out   (hit)
    );

    cache_lru #(
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) lru_inst (
        .clk      (clk),
        .reset    (reset),
        .mru_in   (cache_way_sel),
        .index_in (index),
        .load_in  (load_lru),
        .lru_out  (lru)
    );

endmodule

// ==== cache/cache_control.sv ====
// cache controller: idle, compare, then writeback and refill on a miss
// hits ack two cycles after stb is first seen
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_control
    import cache_pkg::*;
#(
    parameter int ASSOCIATIVITY = `CACHE_WAYS
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cpu_stb,
    input  logic                             cpu_we,
    input  logic [ASSOCIATIVITY-1:0]         hit,
    input  logic                             dirty,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] lru,
    input  logic                             mem_ack,
    output logic                             cpu_ack,
    output logic                             mem_stb,
    output logic                             mem_we,
    output logic [$clog2(ASSOCIATIVITY)-1:0] cache_way_sel,
    output logic                             input_data_source_sel,
    output logic                             tag_bypass_sel,
    output logic                             load,
    output logic                             load_lru
);

    localparam int WAY_W = $clog2(ASSOCIATIVITY);

    ctrl_state_t      state;
    ctrl_state_t      state_next;
    logic [WAY_W-1:0] way_q;     // way picked in compare, held after
    logic [WAY_W-1:0] hit_way;
    logic             ack_seen;  // forces the stb gap after a mem ack

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (hit[w]) hit_way = WAY_W'(w);
        end
    end

    // ----------------------------------------
    // next state and datapath selects
    // ----------------------------------------
    always_comb begin
        state_next            = state;
        cache_way_sel         = way_q;
        input_data_source_sel = 1'b0;
        tag_bypass_sel        = 1'b0;
        load                  = 1'b0;
        load_lru              = 1'b0;
        mem_stb               = 1'b0;
        mem_we                = 1'b0;
        case (state)
            idle: begin
                if (cpu_stb && !cpu_ack) state_next = compare;  // skip the ack cycle
            end
            compare: begin
                if (|hit) begin
                    cache_way_sel = hit_way;
                    load          = cpu_we;
                    load_lru      = 1'b1;
                    state_next    = idle;
                end else begin
                    cache_way_sel = lru;  // victim
                    state_next    = dirty ? writeback : refill;
                end
            end
            writeback: begin
                mem_stb = !ack_seen;
                mem_we  = 1'b1;
                if (mem_ack) state_next = refill;
            end
            refill: begin
                input_data_source_sel = 1'b1;
                tag_bypass_sel        = 1'b1;
                mem_stb               = !ack_seen;
                load                  = mem_ack;  // line valid with ack
                if (mem_ack) state_next = compare;
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            way_q    <= '0;
            cpu_ack  <= 1'b0;
            ack_seen <= 1'b0;
        end else begin
            state    <= state_next;
            way_q    <= cache_way_sel;
            cpu_ack  <= (state == compare) && (|hit);
            ack_seen <= mem_ack;
        end
    end

endmodule

// ==== cache/cache.sv ====
// one write-back cache, controller plus datapath
// cpu bus in, memory bus out
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache
    import cache_pkg::*;
#(
    parameter int ASSOCIATIVITY = `CACHE_WAYS
) (
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t cpu_req,
    output wb_rsp_t cpu_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);

    logic [$clog2(ASSOCIATIVITY)-1:0] way_sel;
    logic [$clog2(ASSOCIATIVITY)-1:0] lru;
    logic [ASSOCIATIVITY-1:0]         hit;
    logic                             data_src_sel;
    logic                             tag_bypass_sel;
    logic                             load;
    logic                             load_lru;
    logic                             dirty;
    logic                             cpu_ack;
    logic                             mem_stb;
    logic                             mem_we;
    line_t                            cpu_rdata;
    line_t                            mem_wdata;
    adr_t                             mem_adr;
    sel_t                             mem_sel;

    cache_control #(
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) control_inst (
        .clk                   (clk),
        .reset                 (reset),
        .cpu_stb               (cpu_req.stb),
        .cpu_we                (cpu_req.we),
        .hit                   (hit),
        .dirty                 (dirty),
        .lru                   (lru),
        .mem_ack               (mem_rsp.ack),
        .cpu_ack               (cpu_ack),
        .mem_stb               (mem_stb),
        .mem_we                (mem_we),
        .cache_way_sel         (way_sel),
        .input_data_source_sel (data_src_sel),
        .tag_bypass_sel        (tag_bypass_sel),
        .load                  (load),
        .load_lru              (load_lru)
    );

    cache_datapath #(
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) datapath_inst (
        .clk                   (clk),
        .reset                 (reset),
        .cache_way_sel         (way_sel),
        .input_data_source_sel (data_src_sel),
        .tag_bypass_sel        (tag_bypass_sel),
        .load                  (load),
        .load_lru              (load_lru),
        .cpu_req               (cpu_req),
        .mem_rdata             (mem_rsp.dat),
        .hit                   (hit),
        .dirty                 (dirty),
        .lru                   (lru),
        .cpu_rdata             (cpu_rdata),
        .mem_adr               (mem_adr),
        .mem_sel               (mem_sel),
        .mem_wdata             (mem_wdata)
    );

    // pack the bus structs
    assign cpu_rsp = '{ack: cpu_ack, dat: cpu_rdata};
    assign mem_req = '{stb: mem_stb, we: mem_we, adr: mem_adr, sel: mem_sel, dat: mem_wdata};

endmodule

// ==== hdl/mem_arbiter.sv ====
// round-robin arbiter, two caches onto one memory bus
// combinational steering, grant held for a whole transaction
`timescale 1ns/1ns

module mem_arbiter
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t req0,
    input  wb_req_t req1,
    output wb_rsp_t rsp0,
    output wb_rsp_t rsp1,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);

    logic [1:0] stb_vec;
    logic       grant;  // preferred / current owner
    logic       owner;  // who drives the bus this cycle

    assign stb_vec = {req1.stb, req0.stb};

    // the holder keeps the bus while its stb is up
    always_comb begin
        if (stb_vec[grant]) owner = grant;
        else if (stb_vec[~grant]) owner = ~grant;
        else owner = grant;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= 1'b0;
        end else if (mem_rsp.ack) begin
            grant <= ~owner;  // other side goes first next time
        end else begin
            grant <= owner;   // only moves while the holder is idle
        end
    end

    // ----------------------------------------
    // steering
    // ----------------------------------------
    assign mem_req = owner ? req1 : req0;

    assign rsp0 = '{ack: mem_rsp.ack & ~owner, dat: mem_rsp.dat};
    assign rsp1 = '{ack: mem_rsp.ack & owner, dat: mem_rsp.dat};

endmodule

// ==== hdl/main_memory.sv ====
// line-wide main memory model, one line per address
// ack pulses MEM_ACK_LATENCY cycles into a request
`timescale 1ns/1ns
`include "cache_macros.svh"

module main_memory
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    localparam int CNT_W = $clog2(`MEM_ACK_LATENCY + 1);

    line_t            mem [2**$bits(adr_t)];
    logic [CNT_W-1:0] cnt;
    logic             ack_q;
    line_t            dat_q;
    logic             active;  // request seen, not yet acked
    logic             done;

    assign active = req.stb && !ack_q;
    assign done   = active && (cnt == CNT_W'(`MEM_ACK_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt   <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= done;
            if (done) cnt <= '0;
            else if (active) cnt <= cnt + 1'b1;
        end
    end

    // access happens on the ack cycle
    always_ff @(posedge clk) begin
        if (done) begin
            dat_q <= mem[req.adr];
            if (req.we) begin
                for (int b = 0; b < $bits(sel_t); b++) begin
                    if (req.sel[b]) mem[req.adr][8*b +: 8] <= req.dat[8*b +: 8];
                end
            end
        end
    end

    assign rsp = '{ack: ack_q, dat: dat_q};

endmodule

// ==== hdl/cache_system.sv ====
// two-port cache system: two caches share main memory through the arbiter
// port 0 owns adr[11] clear, port 1 owns adr[11] set
`timescale 1ns/1ns
`include "cache_macros.svh"

module cache_system
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t cpu0_req,
    input  wb_req_t cpu1_req,
    output wb_rsp_t cpu0_rsp,
    output wb_rsp_t cpu1_rsp
);

    wb_req_t c0_mem_req;
    wb_req_t c1_mem_req;
    wb_rsp_t c0_mem_rsp;
    wb_rsp_t c1_mem_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    // ----------------------------------------
    // caches
    // ----------------------------------------
    cache #(.ASSOCIATIVITY(`CACHE_WAYS)) cache0_inst (
        .clk     (clk),
        .reset   (reset),
        .cpu_req (cpu0_req),
        .cpu_rsp (cpu0_rsp),
        .mem_req (c0_mem_req),
        .mem_rsp (c0_mem_rsp)
    );

    cache #(.ASSOCIATIVITY(`CACHE_WAYS)) cache1_inst (
        .clk     (clk),
        .reset   (reset),
        .cpu_req (cpu1_req),
        .cpu_rsp (cpu1_rsp),
        .mem_req (c1_mem_req),
        .mem_rsp (c1_mem_rsp)
    );

    // ----------------------------------------
    // shared memory side
    // ----------------------------------------
    mem_arbiter arbiter_inst (
        .clk     (clk),
        .reset   (reset),
        .req0    (c0_mem_req),
        .req1    (c1_mem_req),
        .rsp0    (c0_mem_rsp),
        .rsp1    (c1_mem_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    main_memory memory_inst (
        .clk   (clk),
        .reset (reset),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

// ==== verification/cache_checker.sv ====
// watches both cpu ports of the cache system against a shadow memory
// checks read data and latency class, counts errors for the testbench top
`timescale 1ns/1ns

module cache_checker
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t cpu0_req,
    input  wb_rsp_t cpu0_rsp,
    input  wb_req_t cpu1_req,
    input  wb_rsp_t cpu1_rsp,
    input  logic [1:0] lat_expect0,   // bit 0 hit expected, bit 1 miss expected
    input  logic [1:0] lat_expect1,
    output int      error_count,
    output int      read_count,
    output int      hit_count,
    output int      miss_count
);

    localparam int HIT_CYCLES = 2;  // one cycle idle, one in compare

    wb_req_t    req [2];
    wb_rsp_t    rsp [2];
    logic [1:0] lat_exp [2];
    logic       busy [2];
    int         start [2];
    int         cycle;
    line_t      shadow [4096];
    bit         written [4096];

    assign req[0]     = cpu0_req;
    assign req[1]     = cpu1_req;
    assign rsp[0]     = cpu0_rsp;
    assign rsp[1]     = cpu1_rsp;
    assign lat_exp[0] = lat_expect0;
    assign lat_exp[1] = lat_expect1;

    // expected line after a write under byte selects
    function automatic line_t merge_bytes(line_t old_line, line_t new_data, sel_t sel);
        line_t line;
        line = old_line;
        for (int b = 0; b < 16; b++) begin
            if (sel[b]) line[8*b +: 8] = new_data[8*b +: 8];
        end
        return line;
    endfunction

    // ----------------------------------------
    // per-port transaction tracking
    // ----------------------------------------
    always @(posedge clk) begin
        int    lat;
        adr_t  adr;
        line_t expected;
        cycle++;
        if (reset) begin
            busy[0] = 1'b0;
            busy[1] = 1'b0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                adr = req[p].adr;
                if (rsp[p].ack && !busy[p]) begin
                    error_count++;
                    $display("port %0d raised ack with no request outstanding", p);
                end else if (rsp[p].ack) begin
                    busy[p] = 1'b0;
                    lat = cycle - start[p];
                    if (lat == HIT_CYCLES) hit_count++;
                    else miss_count++;
                    if (lat < HIT_CYCLES) begin
                        error_count++;
                        $display("port %0d acked after %0d cycles, faster than a hit", p, lat);
                    end
                    if (lat_exp[p][0] && lat != HIT_CYCLES) begin
                        error_count++;
                        $display("port %0d adr 0x%03h took %0d cycles, expected a hit", p, adr, lat);
                    end
                    if (lat_exp[p][1] && lat <= HIT_CYCLES) begin
                        error_count++;
                        $display("port %0d adr 0x%03h hit, expected a miss", p, adr);
                    end
                    if (req[p].we) begin
                        shadow[adr]  = merge_bytes(shadow[adr], req[p].dat, req[p].sel);
                        written[adr] = 1'b1;
                    end else if (!written[adr]) begin
                        error_count++;
                        $display("port %0d read adr 0x%03h before any write to it", p, adr);
                    end else begin
                        read_count++;
                        expected = shadow[adr];
                        if (rsp[p].dat !== expected) begin
                            error_count++;
                            $display("ERROR cpu%0d_rsp.dat adr 0x%03h: got 0x%032h, expected 0x%032h",
                                     p, adr, rsp[p].dat, expected);
                        end
                    end
                end else if (req[p].stb && !busy[p]) begin
                    busy[p]  = 1'b1;  // first cycle stb is seen
                    start[p] = cycle;
                end
            end
        end
    end

endmodule

// ==== verification/cache_system_tb.sv ====
// testbench for the two-port cache system: clock, reset, directed and random traffic
// compile with tb.f, top is cache_system_tb; cache_checker does the comparing
`timescale 1ns/1ns

module cache_system_tb
    import cache_pkg::*;
();

    localparam logic [1:0] LAT_ANY  = 2'b00;
    localparam logic [1:0] LAT_HIT  = 2'b01;
    localparam logic [1:0] LAT_MISS = 2'b10;
    localparam int RAND_OPS = 200;  // per port
    // about 420 operations, worst miss near 24 cycles with contention, doubled
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk = 1'b0;
    logic       reset;
    wb_req_t    cpu0_req;
    wb_req_t    cpu1_req;
    wb_rsp_t    cpu0_rsp;
    wb_rsp_t    cpu1_rsp;
    logic [1:0] lat_expect0;
    logic [1:0] lat_expect1;
    int         error_count;
    int         read_count;
    int         hit_count;
    int         miss_count;
    int         tests_run;
    int         tests_failed;
    int         test_errs_start;
    int         cycles;
    bit         written [4096];

    always #2 clk = ~clk;

    cache_system cache_system_inst (
        .clk      (clk),
        .reset    (reset),
        .cpu0_req (cpu0_req),
        .cpu1_req (cpu1_req),
        .cpu0_rsp (cpu0_rsp),
        .cpu1_rsp (cpu1_rsp)
    );

    cache_checker checker_inst (
        .clk         (clk),
        .reset       (reset),
        .cpu0_req    (cpu0_req),
        .cpu0_rsp    (cpu0_rsp),
        .cpu1_req    (cpu1_req),
        .cpu1_rsp    (cpu1_rsp),
        .lat_expect0 (lat_expect0),
        .lat_expect1 (lat_expect1),
        .error_count (error_count),
        .read_count  (read_count),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    function automatic line_t random_line();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // ----------------------------------------
    // one bus transaction on one cpu port
    // ----------------------------------------
    task automatic access(input int port, input logic we, input adr_t adr, input sel_t sel,
                          input line_t dat, input logic [1:0] lat);
        wb_req_t req;
        logic    ack;
        req = '{stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
        @(posedge clk);
        #1;
        if (port == 0) begin
            cpu0_req    = req;
            lat_expect0 = lat;
        end else begin
            cpu1_req    = req;
            lat_expect1 = lat;
        end
        ack = 1'b0;
        while (!ack) begin
            @(posedge clk);
            ack = (port == 0) ? cpu0_rsp.ack : cpu1_rsp.ack;
        end
        #1;
        if (port == 0) begin
            cpu0_req.stb = 1'b0;  // gap cycle after ack
            lat_expect0  = LAT_ANY;
        end else begin
            cpu1_req.stb = 1'b0;
            lat_expect1  = LAT_ANY;
        end
        if (we) written[adr] = 1'b1;
    endtask

    // 4 tags per set in the port's own half, so evictions happen
    task automatic random_ops(input int port, input int count);
        adr_t adr;
        for (int i = 0; i < count; i++) begin
            adr = adr_t'((port << 11) | ($urandom % 32));
            if (!written[adr]) access(port, 1'b1, adr, '1, random_line(), LAT_ANY);
            else if ($urandom % 2) access(port, 1'b0, adr, '0, '0, LAT_ANY);
            else access(port, 1'b1, adr, sel_t'($urandom), random_line(), LAT_ANY);
        end
    endtask

    task automatic end_test(input string name);
        int    errs;
        string verdict;
        errs = error_count - test_errs_start;
        tests_run++;
        if (errs != 0) tests_failed++;
        verdict = (errs == 0) ? "ok" : "failed";
        $display("test %0d %s: %s (%0d errors)", tests_run, name, verdict, errs);
        test_errs_start = error_count;
    endtask

    initial begin
        void'($urandom(46599));
        cpu0_req    = '0;
        cpu1_req    = '0;
        lat_expect0 = LAT_ANY;
        lat_expect1 = LAT_ANY;
        reset       = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (20) @(posedge clk);  // checker flags any stray ack
        end_test("no ack while idle");

        access(0, 1'b1, 12'h001, '1, random_line(), LAT_ANY);
        access(0, 1'b0, 12'h001, '0, '0, LAT_HIT);
        end_test("write then read hits");

        access(1, 1'b1, 12'h802, '1, random_line(), LAT_ANY);
        access(1, 1'b1, 12'h802, 16'h0ff0, random_line(), LAT_ANY);
        access(1, 1'b0, 12'h802, '0, '0, LAT_HIT);
        end_test("partial write merge");

        // set 3, third tag evicts the dirty first one
        access(0, 1'b1, 12'h003, '1, random_line(), LAT_ANY);
        access(0, 1'b1, 12'h00b, '1, random_line(), LAT_ANY);
        access(0, 1'b1, 12'h013, '1, random_line(), LAT_ANY);
        access(0, 1'b0, 12'h003, '0, '0, LAT_MISS);
        end_test("dirty eviction");

        // set 5, reading A makes B the victim of C
        access(0, 1'b1, 12'h005, '1, random_line(), LAT_ANY);
        access(0, 1'b1, 12'h00d, '1, random_line(), LAT_ANY);
        access(0, 1'b0, 12'h005, '0, '0, LAT_HIT);
        access(0, 1'b1, 12'h015, '1, random_line(), LAT_ANY);
        access(0, 1'b0, 12'h005, '0, '0, LAT_HIT);
        access(0, 1'b0, 12'h00d, '0, '0, LAT_MISS);
        end_test("lru order");

        fork
            random_ops(0, RAND_OPS);
            random_ops(1, RAND_OPS);
        join
        end_test("random traffic on both ports");

        $display("tests %0d, failed %0d, reads checked %0d, hits %0d, misses %0d, errors %0d",
                 tests_run, tests_failed, read_count, hit_count, miss_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // ----------------------------------------
    // run limit
    // ----------------------------------------
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
+incdir+common
common/cache_pkg.sv
cache/cache_way.sv
cache/cache_lru.sv
cache/cache_datapath.sv
cache/cache_control.sv
cache/cache.sv
hdl/mem_arbiter.sv
hdl/main_memory.sv
hdl/cache_system.sv
verification/cache_checker.sv
verification/cache_system_tb.sv
